//--- eeprom_i2c.f
+incdir+hdl
hdl/i2c_bus_pkg.sv
hdl/eeprom_pkg.sv
hdl/i2c_line_monitor.sv
hdl/eeprom_protocol_fsm.sv
hdl/eeprom_array.sv
hdl/eeprom_i2c.sv
tb/eeprom_i2c_asserts.sv
tb/eeprom_i2c_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f eeprom_i2c.f \
    --top-module eeprom_i2c_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Veeprom_i2c_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1

//--- tb/eeprom_i2c_tb.sv
`default_nettype none

module eeprom_i2c_tb;

    localparam int clk_period  = 20;
    localparam int half_cycles = 10;
    localparam int qtr_cycles  = 5;
    localparam int bit_period  = 2 * half_cycles * clk_period;
    // start conditions over the whole run, rounded up
    localparam int num_trans    = 44;
    localparam int timeout_time = num_trans * 30 * bit_period * 2;

    logic scl = 1'b0;
    logic arst_n = 1'b0;
    logic bus_clk = 1'b1;
    logic sda_drv = 1'b1;
    logic sda_oe;
    wire  sda;

    logic [7:0] ref_mem [2048];
    int         seed;
    int         checks = 0;
    int         errors = 0;

    string      name_q [$];
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    time        time_q [$];
    string      cmp_name;
    logic [7:0] cmp_exp;
    logic [7:0] cmp_got;
    time        cmp_time;

    // open drain, either side pulls low
    assign sda = sda_drv & ~sda_oe;

    eeprom_i2c UUT (
        .scl     (scl),
        .arst_n  (arst_n),
        .bus_clk (bus_clk),
        .sda_in  (sda),
        .sda_oe  (sda_oe)
    );

    always #(clk_period / 2) scl = ~scl;

    function automatic logic [7:0] expected_byte(input int addr);
        return ref_mem[11'(addr % 2048)];
    endfunction

    function automatic logic [7:0] control_byte(input logic [2:0] blk, input logic rd);
        return {4'b1010, blk, rd};
    endfunction

    task automatic post_check(input string name, input logic [7:0] exp, input logic [7:0] got);
        name_q.push_back(name);
        exp_q.push_back(exp);
        got_q.push_back(got);
        time_q.push_back($time);
    endtask

    always @(posedge scl)
    begin
        while (got_q.size() > 0)
        begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_got  = got_q.pop_front();
            cmp_time = time_q.pop_front();
            checks++;
            assert (cmp_got === cmp_exp)
            else
            begin
                errors++;
                $display("error: time %0t signal %s expected %02h got %02h",
                         cmp_time, cmp_name, cmp_exp, cmp_got);
            end
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge scl);
    endtask

    // data changes mid low phase, sampled at the end of the high phase
    task automatic clock_bit(input logic b, output logic s);
        wait_cycles(qtr_cycles);
        sda_drv = b;
        wait_cycles(qtr_cycles);
        bus_clk = 1'b1;
        wait_cycles(half_cycles);
        s = sda;
        bus_clk = 1'b0;
    endtask

    task automatic bus_start();
        wait_cycles(qtr_cycles);
        sda_drv = 1'b1;
        wait_cycles(qtr_cycles);
        bus_clk = 1'b1;
        wait_cycles(half_cycles);
        sda_drv = 1'b0;
        wait_cycles(half_cycles);
        bus_clk = 1'b0;
    endtask

    task automatic bus_stop();
        wait_cycles(qtr_cycles);
        sda_drv = 1'b0;
        wait_cycles(qtr_cycles);
        bus_clk = 1'b1;
        wait_cycles(half_cycles);
        sda_drv = 1'b1;
        wait_cycles(half_cycles);
    endtask

    task automatic send_byte(input logic [7:0] b, output logic ack);
        logic [7:0] sh;
        logic       s;
        sh = b;
        repeat (8)
        begin
            clock_bit(sh[7], s);
            sh = {sh[6:0], 1'b0};
        end
        clock_bit(1'b1, ack);
    endtask

    task automatic recv_byte(input logic nack, output logic [7:0] d);
        logic s;
        d = '0;
        repeat (8)
        begin
            clock_bit(1'b1, s);
            d = {d[6:0], s};
        end
        clock_bit(nack, s);
    endtask

    task automatic send_acked(input logic [7:0] b);
        logic ack;
        send_byte(b, ack);
        post_check("ack", 8'h00, {7'b0, ack});
    endtask

    task automatic byte_write(input logic [10:0] addr, input logic [7:0] data);
        bus_start();
        send_acked(control_byte(addr[10:8], 1'b0));
        send_acked(addr[7:0]);
        send_acked(data);
        bus_stop();
        ref_mem[addr] = data;
    endtask

    // dummy write loads the pointer, then a repeated start reads on
    task automatic read_from(input logic [10:0] addr, input int count);
        logic [7:0] d;
        bus_start();
        send_acked(control_byte(addr[10:8], 1'b0));
        send_acked(addr[7:0]);
        bus_start();
        send_acked(control_byte(addr[10:8], 1'b1));
        for (int i = 0; i < count; i++)
        begin
            recv_byte(i == count - 1, d);
            post_check("read_data", expected_byte(int'(addr) + i), d);
        end
        bus_stop();
    endtask

    initial
    begin
        logic [10:0] addr;
        logic [10:0] addr2;
        logic [7:0]  data;
        logic [7:0]  data2;
        logic [7:0]  d;
        logic        ack;
        seed = 99;
        for (int i = 0; i < 2048; i++)
            ref_mem[11'(i)] = 8'h00;
        wait_cycles(10);
        arst_n = 1'b1;
        wait_cycles(2);
        post_check("sda_oe", 8'h00, {7'b0, sda_oe});

        // nothing written yet
        addr = 11'($random(seed));
        read_from(addr, 1);

        addr = 11'($random(seed));
        data = 8'($random(seed));
        byte_write(addr, data);
        read_from(addr, 1);

        // foreign device code, write then read
        bus_start();
        send_byte({4'b0110, 3'b000, 1'b0}, ack);
        post_check("ack", 8'h01, {7'b0, ack});
        send_byte(8'h3c, ack);
        post_check("ack", 8'h01, {7'b0, ack});
        bus_stop();
        bus_start();
        send_byte({4'b1011, 3'b010, 1'b1}, ack);
        post_check("ack", 8'h01, {7'b0, ack});
        recv_byte(1'b1, d);
        post_check("read_data", 8'hff, d);
        bus_stop();
        addr = 11'($random(seed));
        data = 8'($random(seed));
        byte_write(addr, data);
        read_from(addr, 1);

        // same word address under other block bits
        addr  = 11'($random(seed));
        addr2 = {~addr[10:8], addr[7:0]};
        data  = 8'($random(seed));
        data2 = ~data;
        byte_write(addr, data);
        byte_write(addr2, data2);
        read_from(addr, 1);
        read_from(addr2, 1);

        // pointer wraps from 2047 to 0
        for (int i = 0; i < 5; i++)
            byte_write(11'(2046 + i), 8'($random(seed)));
        read_from(11'd2046, 5);

        // stop after half a data byte
        addr = 11'($random(seed));
        data = 8'($random(seed));
        byte_write(addr, data);
        bus_start();
        send_acked(control_byte(addr[10:8], 1'b0));
        send_acked(addr[7:0]);
        data2 = ~data;
        repeat (4)
        begin
            clock_bit(data2[7], ack);
            data2 = {data2[6:0], 1'b0};
        end
        bus_stop();
        read_from(addr, 1);

        repeat (4)
        begin
            addr = 11'($random(seed));
            data = 8'($random(seed));
            byte_write(addr, data);
            read_from(addr, 1);
        end

        wait_cycles(4);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0 && checks > 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        #(timeout_time);
        $display("watchdog expired before the bus transfers finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/eeprom_i2c_asserts.sv
`default_nettype none

module eeprom_i2c_asserts
    import i2c_bus_pkg::*;
(
    input logic        scl,
    input logic        arst_n,
    input logic        bus_clk,
    input line_event_e line_event,
    input logic        sda_oe,
    input logic        mem_we
);

    sync_chain_t clk_sync;
    logic        bus_clk_high;

    // bus clock through a synchronizer as deep as the slave's
    assign bus_clk_high = clk_sync[$bits(sync_chain_t)-1];

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
            clk_sync <= '1;
        else
            clk_sync <= {clk_sync[$bits(sync_chain_t)-2:0], bus_clk};
    end

    oe_rise_clk_low: assert property (@(posedge scl) disable iff (!arst_n)
        $rose(sda_oe) |-> !bus_clk_high)
        else $error("sda_oe rose while the bus clock was high");

    we_one_cycle: assert property (@(posedge scl) disable iff (!arst_n)
        mem_we |=> !mem_we)
        else $error("mem_we stayed high for more than one cycle");

    oe_low_after_stop: assert property (@(posedge scl) disable iff (!arst_n)
        (line_event == ev_stop) |=> !sda_oe)
        else $error("sda_oe still high in the cycle after a stop");

endmodule

bind eeprom_i2c eeprom_i2c_asserts u_asserts (
    .scl        (scl),
    .arst_n     (arst_n),
    .bus_clk    (bus_clk),
    .line_event (line_event),
    .sda_oe     (sda_oe),
    .mem_we     (mem_we)
);

`default_nettype wire

//--- hdl/eeprom_i2c.sv
`default_nettype none

module eeprom_i2c
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic arst_n,
    input  logic bus_clk,
    input  logic sda_in,
    output logic sda_oe
);

    line_event_e line_event;
    logic        sda_level;
    mem_addr_t   mem_addr;
    mem_word_t   mem_wdata;
    logic        mem_we;
    mem_word_t   mem_rdata;

    i2c_line_monitor u_monitor (
        .scl        (scl),
        .arst_n     (arst_n),
        .bus_clk    (bus_clk),
        .sda_in     (sda_in),
        .line_event (line_event),
        .sda_level  (sda_level)
    );

    eeprom_protocol_fsm u_fsm (
        .scl        (scl),
        .arst_n     (arst_n),
        .line_event (line_event),
        .sda_level  (sda_level),
        .sda_oe     (sda_oe),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .mem_rdata  (mem_rdata)
    );

    eeprom_array u_array (
        .scl       (scl),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/eeprom_array.sv
`default_nettype none

module eeprom_array
    import eeprom_pkg::*;
(
    input  logic      scl,
    input  mem_addr_t mem_addr,
    input  mem_word_t mem_wdata,
    input  logic      mem_we,
    output mem_word_t mem_rdata
);

    mem_word_t mem [mem_depth];

    // erased part reads back as zero
    initial
    begin
        for (int i = 0; i < mem_depth; i++)
            mem[mem_addr_t'(i)] = '0;
    end

    always_ff @(posedge scl)
    begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        mem_rdata <= mem[mem_addr];
    end

endmodule

`default_nettype wire

//--- hdl/eeprom_protocol_fsm.sv
`default_nettype none

module eeprom_protocol_fsm
    import i2c_bus_pkg::*;
    import eeprom_pkg::*;
(
    input  logic        scl,
    input  logic        arst_n,
    input  line_event_e line_event,
    input  logic        sda_level,
    output logic        sda_oe,
    output mem_addr_t   mem_addr,
    output mem_word_t   mem_wdata,
    output logic        mem_we,
    input  mem_word_t   mem_rdata
);

    phase_e    phase;
    logic [2:0] bit_cnt;
    logic      slot_done;
    logic      read_op;
    logic [2:0] block;
    mem_addr_t addr_ptr;
    mem_word_t rx_shift;
    mem_word_t tx_shift;
    mem_word_t rx_byte;
    logic      is_sample;
    logic      is_shift;
    logic      byte_done;
    logic      load_tx;

    assign is_sample = (line_event == ev_sample);
    assign is_shift  = (line_event == ev_shift);
    assign rx_byte   = {rx_shift[6:0], sda_level};
    assign byte_done = is_sample && (bit_cnt == 3'd7);
    assign mem_addr  = addr_ptr;

    // next outgoing byte loads after the control ack or a master ack
    assign load_tx = is_shift && slot_done &&
                     ((phase == ph_control_ack && read_op) || phase == ph_master_ack);

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase     <= ph_idle;
            bit_cnt   <= '0;
            slot_done <= 1'b0;
            read_op   <= 1'b0;
            block     <= '0;
            addr_ptr  <= '0;
            sda_oe    <= 1'b0;
            mem_we    <= 1'b0;
        end
        else
        begin
            mem_we <= 1'b0;
            if (line_event == ev_stop)
            begin
                phase  <= ph_idle;
                sda_oe <= 1'b0;
            end
            else if (line_event == ev_start)
            begin
                phase     <= ph_control;
                bit_cnt   <= '0;
                slot_done <= 1'b0;
                sda_oe    <= 1'b0;
            end
            else if (load_tx)
            begin
                phase   <= ph_read_data;
                bit_cnt <= '0;
                sda_oe  <= ~mem_rdata[7];
            end
            else
            begin
                case (phase)
                    ph_control:
                    begin
                        if (is_sample)
                            bit_cnt <= bit_cnt + 3'd1;
                        if (byte_done)
                        begin
                            slot_done <= 1'b0;
                            if (rx_byte[7:4] == device_code)
                            begin
                                phase   <= ph_control_ack;
                                read_op <= rx_byte[0];
                                if (!rx_byte[0])
                                    block <= rx_byte[3:1];
                            end
                            else
                            begin
                                phase <= ph_idle;
                            end
                        end
                    end
                    ph_word_addr, ph_write_data:
                    begin
                        if (is_sample)
                            bit_cnt <= bit_cnt + 3'd1;
                        if (byte_done)
                        begin
                            slot_done <= 1'b0;
                            if (phase == ph_word_addr)
                            begin
                                phase    <= ph_addr_ack;
                                addr_ptr <= {block, rx_byte};
                            end
                            else
                            begin
                                phase  <= ph_write_ack;
                                mem_we <= 1'b1;
                            end
                        end
                    end
                    ph_control_ack, ph_addr_ack, ph_write_ack:
                    begin
                        if (is_sample)
                            slot_done <= 1'b1;
                        if (is_shift && !slot_done)
                            sda_oe <= 1'b1;
                        if (is_shift && slot_done)
                        begin
                            sda_oe  <= 1'b0;
                            bit_cnt <= '0;
                            // single byte writes only
                            if (phase == ph_control_ack)
                                phase <= ph_word_addr;
                            else if (phase == ph_addr_ack)
                                phase <= ph_write_data;
                            else
                                phase <= ph_idle;
                        end
                    end
                    ph_read_data:
                    begin
                        if (is_shift)
                            sda_oe <= ~tx_shift[7];
                        if (is_sample)
                            bit_cnt <= bit_cnt + 3'd1;
                        if (byte_done)
                        begin
                            phase     <= ph_master_ack;
                            slot_done <= 1'b0;
                        end
                    end
                    ph_master_ack:
                    begin
                        // release the line for the master ack bit
                        if (is_shift)
                            sda_oe <= 1'b0;
                        if (is_sample)
                        begin
                            if (!sda_level)
                            begin
                                slot_done <= 1'b1;
                                addr_ptr  <= addr_ptr + mem_addr_t'(1);
                            end
                            else
                            begin
                                phase <= ph_idle;
                            end
                        end
                    end
                    default:
                    begin
                        phase <= ph_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (is_sample)
            rx_shift <= rx_byte;
        if (byte_done && phase == ph_write_data)
            mem_wdata <= rx_byte;
        if (load_tx)
            tx_shift <= {mem_rdata[6:0], 1'b0};
        else if (is_shift && phase == ph_read_data)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

endmodule

`default_nettype wire

//--- hdl/i2c_line_monitor.sv
`default_nettype none

`include "eeprom_consts.svh"

module i2c_line_monitor
    import i2c_bus_pkg::*;
(
    input  logic        scl,
    input  logic        arst_n,
    input  logic        bus_clk,
    input  logic        sda_in,
    output line_event_e line_event,
    output logic        sda_level
);

    sync_chain_t clk_sync;
    sync_chain_t sda_sync;
    logic        clk_prev;
    logic        sda_prev;
    logic        clk_now;
    logic        sda_now;
    line_event_e event_next;

    assign clk_now   = clk_sync[`EEPROM_SYNC_STAGES-1];
    assign sda_now   = sda_sync[`EEPROM_SYNC_STAGES-1];
    assign sda_level = sda_prev;

    // start and stop only count while the clock line is high
    always_comb
    begin
        event_next = ev_none;
        if (clk_now && sda_prev && !sda_now)
            event_next = ev_start;
        else if (clk_now && !sda_prev && sda_now)
            event_next = ev_stop;
        else if (clk_now && !clk_prev)
            event_next = ev_sample;
        else if (!clk_now && clk_prev)
            event_next = ev_shift;
    end

    // idle bus is high on both lines
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_sync   <= '1;
            sda_sync   <= '1;
            clk_prev   <= 1'b1;
            sda_prev   <= 1'b1;
            line_event <= ev_none;
        end
        else
        begin
            clk_sync   <= {clk_sync[`EEPROM_SYNC_STAGES-2:0], bus_clk};
            sda_sync   <= {sda_sync[`EEPROM_SYNC_STAGES-2:0], sda_in};
            clk_prev   <= clk_now;
            sda_prev   <= sda_now;
            line_event <= event_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/eeprom_pkg.sv
`default_nettype none

`include "eeprom_consts.svh"

package eeprom_pkg;

    localparam int unsigned mem_depth = `EEPROM_DEPTH;
    localparam logic [3:0] device_code = `EEPROM_DEVICE_CODE;

    typedef logic [`EEPROM_DATA_W-1:0] mem_word_t;
    typedef logic [`EEPROM_ADDR_W-1:0] mem_addr_t;

    typedef enum logic [3:0] {
        ph_idle,
        ph_control,
        ph_control_ack,
        ph_word_addr,
        ph_addr_ack,
        ph_write_data,
        ph_write_ack,
        ph_read_data,
        ph_master_ack
    } phase_e;

endpackage

`default_nettype wire

//--- hdl/i2c_bus_pkg.sv
`default_nettype none

`include "eeprom_consts.svh"

package i2c_bus_pkg;

    // one bus event per scl cycle
    typedef enum logic [2:0] {
        ev_none,
        ev_start,
        ev_stop,
        ev_sample,
        ev_shift
    } line_event_e;

    typedef logic [`EEPROM_SYNC_STAGES-1:0] sync_chain_t;

endpackage

`default_nettype wire

//--- hdl/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// full byte address, block bits plus word address
`define EEPROM_ADDR_W 11

`define EEPROM_DATA_W 8

`define EEPROM_DEPTH 2048

// upper nibble of every control byte
`define EEPROM_DEVICE_CODE 4'b1010

// flops per bus line synchronizer
`define EEPROM_SYNC_STAGES 2

`endif
